// ==== Makefile ====
# Verilator build and run of the AHB arbiter testbench

VERILATOR ?= verilator
TOP       ?= tbArbiter
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell cat $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== src.f ====
verilog/ahbPkg.sv
verilog/arbPkg.sv
verilog/grantSelect.sv
verilog/burstTracker.sv
verilog/lockTracker.sv
verilog/ahbArbiter.sv
tests/tbArbiter.sv

// ==== tests/tbArbiter.sv ====
// --------------------
// Testbench for the five-master AHB arbiter
// Applies a table of bus cycles and checks grant, owner and lock
// --------------------
`default_nettype none

module tbArbiter;

  timeunit 1ns;
  timeprecision 100ps;

  import ahbPkg::*;
  import arbPkg::*;

  localparam int numMasters    = numMastersDefault;
  localparam int numRandomRows = 8;
  // Fixed rows plus the rows filled from the LFSR
  localparam int numRows       = 28 + numRandomRows;
  localparam int cycleLimit    = numRows + 20;

  // One bus cycle of stimulus and the values expected after its rising edge
  typedef struct packed {
    logic [numMasters-1:0] busReq;
    logic [numMasters-1:0] hLock;
    busStatusT             bus;
    logic [numMasters-1:0] expGrant;
    masterIdT              expMaster;
    logic                  expLock;
  } rowT;

  logic                  HCLK;
  logic                  HRESETn;
  logic [numMasters-1:0] busReq;
  logic [numMasters-1:0] hLock;
  busStatusT             busStatus;
  logic [numMasters-1:0] hGrant;
  masterIdT              hMaster;
  logic                  hMastLock;

  rowT        rows[$];
  string      testNames[$];
  int         testFirst[$];
  logic [7:0] lfsrState;
  int         errorCount;
  int         cycleCount;

  ahbArbiter #(
    .numMasters (numMasters)
  ) u_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .busReq    (busReq),
    .hLock     (hLock),
    .busStatus (busStatus),
    .hGrant    (hGrant),
    .hMaster   (hMaster),
    .hMastLock (hMastLock)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  // --------------------
  // Reference helpers
  // --------------------

  // Fibonacci LFSR with taps 8, 6, 5 and 4
  function automatic logic [7:0] lfsrNext(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // Rotation rule: the master one below the owner ranks first, the owner last
  // With no request at all the dummy master gets the bus
  function automatic int topRequester(input logic [numMasters-1:0] req, input int owner);
    int idx;
    for (int k = 1; k <= numMasters; k++)
    begin
      idx = (owner - k + numMasters) % numMasters;
      if (req[idx])
      begin
        return idx;
      end
    end
    return 0;
  endfunction

  task automatic addRow(input logic [numMasters-1:0] req, input logic [numMasters-1:0] lock,
                        input htransT trans, input hburstT burst, input logic ready,
                        input hrespT resp, input logic [numMasters-1:0] expGrant,
                        input masterIdT expMaster, input logic expLock);
    rowT row;
    row.busReq       = req;
    row.hLock        = lock;
    row.bus.htrans   = trans;
    row.bus.hburst   = burst;
    row.bus.hready   = ready;
    row.bus.hresp    = resp;
    row.expGrant     = expGrant;
    row.expMaster    = expMaster;
    row.expLock      = expLock;
    rows.push_back(row);
  endtask

  task automatic startTest(input string name);
    testNames.push_back(name);
    testFirst.push_back(rows.size());
  endtask

  // Idle cycles with random requests, expected values from the rotation rule
  // The grant seen after the edge is ranked against the new owner
  task automatic addRandomRows(input int count, input int owner);
    logic [numMasters-1:0] req;
    logic [numMasters-1:0] grant;
    int                    cur;
    int                    next;
    cur = owner;
    for (int n = 0; n < count; n++)
    begin
      for (int b = 0; b < numMasters; b++)
      begin
        lfsrState = lfsrNext(lfsrState);
        req[b]    = lfsrState[0];
      end
      next = topRequester(req, cur);
      grant = '0;
      grant[topRequester(req, next)] = 1'b1;
      addRow(req, '0, transIdle, burstSingle, 1'b1, respOkay, grant, masterIdT'(next), 1'b0);
      cur = next;
    end
  endtask

  // --------------------
  // Stimulus table
  // --------------------

  // Columns: busReq, hLock, htrans, hburst, hready, hresp, then hGrant, hMaster, hMastLock
  task automatic buildTable();
    startTest("reset with no requests");
    addRow(5'b00000, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00001, 3'd0, 1'b0);
    // Everybody asks, so the owner walks down one master per cycle
    startTest("rotating priority");
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b01000, 3'd4, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00100, 3'd3, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00010, 3'd2, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00001, 3'd1, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b10000, 3'd0, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b01000, 3'd4, 1'b0);
    startTest("random requests");
    addRandomRows(numRandomRows, 4);
    // The first row hands the bus back to the dummy master from any owner
    startTest("burst hold");
    addRow(5'b00000, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00001, 3'd0, 1'b0);
    addRow(5'b00100, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00100, 3'd2, 1'b0);
    addRow(5'b00100, 5'b00000, transNonseq, burstIncr4, 1'b1, respOkay, 5'b00100, 3'd2, 1'b0);
    addRow(5'b11111, 5'b00000, transSeq, burstIncr4, 1'b1, respOkay, 5'b00010, 3'd2, 1'b0);
    addRow(5'b11111, 5'b00000, transSeq, burstIncr4, 1'b1, respOkay, 5'b00001, 3'd1, 1'b0);
    // An 8-beat burst cut short by an idle transfer
    addRow(5'b00010, 5'b00000, transNonseq, burstIncr8, 1'b1, respOkay, 5'b00010, 3'd1, 1'b0);
    addRow(5'b11111, 5'b00000, transSeq, burstIncr8, 1'b1, respOkay, 5'b00010, 3'd1, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstIncr8, 1'b1, respOkay, 5'b10000, 3'd0, 1'b0);
    // Master 3 takes the bus and then locks it against higher ranked requests
    startTest("locked transfers");
    addRow(5'b01000, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b01000, 3'd3, 1'b0);
    addRow(5'b01000, 5'b01000, transIdle, burstSingle, 1'b1, respOkay, 5'b01000, 3'd3, 1'b1);
    addRow(5'b11111, 5'b01000, transNonseq, burstSingle, 1'b1, respOkay, 5'b01000, 3'd3, 1'b1);
    addRow(5'b11111, 5'b01000, transNonseq, burstSingle, 1'b1, respOkay, 5'b01000, 3'd3, 1'b1);
    // The lock input drops during the split, yet the lock holds through the response
    startTest("split on locked data");
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b0, respSplit, 5'b01000, 3'd3, 1'b1);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respSplit, 5'b01000, 3'd3, 1'b1);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00100, 3'd3, 1'b0);
    addRow(5'b11111, 5'b00000, transIdle, burstSingle, 1'b1, respOkay, 5'b00010, 3'd2, 1'b0);
    // A retry releases master 1 in the middle of an 8-beat burst
    startTest("retry in burst");
    addRow(5'b00010, 5'b00000, transNonseq, burstIncr8, 1'b1, respOkay, 5'b00010, 3'd1, 1'b0);
    addRow(5'b11111, 5'b00000, transSeq, burstIncr8, 1'b1, respOkay, 5'b00010, 3'd1, 1'b0);
    addRow(5'b11111, 5'b00000, transSeq, burstIncr8, 1'b0, respRetry, 5'b00001, 3'd1, 1'b0);
    addRow(5'b11111, 5'b00000, transBusy, burstIncr8, 1'b1, respRetry, 5'b00001, 3'd0, 1'b0);
    addRow(5'b00000, 5'b00000, transIdle, burstIncr8, 1'b1, respOkay, 5'b00001, 3'd0, 1'b0);
    testFirst.push_back(rows.size());
  endtask

  // --------------------
  // Drive and check
  // --------------------

  task automatic driveRow(input int r);
    busReq    = rows[r].busReq;
    hLock     = rows[r].hLock;
    busStatus = rows[r].bus;
  endtask

  task automatic checkRow(input int r);
    if (hGrant !== rows[r].expGrant)
    begin
      $display("error at time %0t: row %0d hGrant is %b, expected %b",
               $time, r, hGrant, rows[r].expGrant);
      errorCount++;
    end
    if (hMaster !== rows[r].expMaster)
    begin
      $display("error at time %0t: row %0d hMaster is %0d, expected %0d",
               $time, r, hMaster, rows[r].expMaster);
      errorCount++;
    end
    if (hMastLock !== rows[r].expLock)
    begin
      $display("error at time %0t: row %0d hMastLock is %b, expected %b",
               $time, r, hMastLock, rows[r].expLock);
      errorCount++;
    end
  endtask

  initial
  begin
    int failedTests;
    int testErrors;
    HRESETn          = 1'b0;
    busReq           = '0;
    hLock            = '0;
    busStatus.htrans = transIdle;
    busStatus.hburst = burstSingle;
    busStatus.hready = 1'b1;
    busStatus.hresp  = respOkay;
    errorCount       = 0;
    failedTests      = 0;
    lfsrState        = 8'd63;
    buildTable();
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    // Each row is driven on a falling edge and checked late in the high phase
    for (int t = 0; t < testNames.size(); t++)
    begin
      testErrors = errorCount;
      for (int r = testFirst[t]; r < testFirst[t+1]; r++)
      begin
        driveRow(r);
        @(posedge HCLK);
        #15;
        checkRow(r);
        @(negedge HCLK);
      end
      if (errorCount == testErrors)
      begin
        $display("Test %0d, %s: passed", t + 1, testNames[t]);
      end
      else
      begin
        failedTests++;
        $display("Test %0d, %s: failed with %0d errors", t + 1, testNames[t],
                 errorCount - testErrors);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", testNames.size(),
             testNames.size() - failedTests, failedTests, errorCount);
    if (errorCount == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Stops a run that never gets through the table
  initial
  begin
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("The run did not finish the table within %0d clock cycles", cycleLimit);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ahbArbiter.sv ====
// --------------------
// AHB arbiter for five masters, top level
// Joins grant selection, burst tracking and lock tracking
// --------------------
`default_nettype none

module ahbArbiter #(
  parameter int numMasters = arbPkg::numMastersDefault
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic [numMasters-1:0] busReq,
  input  logic [numMasters-1:0] hLock,
  input  ahbPkg::busStatusT     busStatus,
  output logic [numMasters-1:0] hGrant,
  output arbPkg::masterIdT      hMaster,
  output logic                  hMastLock
);

  import arbPkg::*;

  // Master chosen this cycle, before it takes the address phase
  masterIdT   grantMaster;
  // Hold flags from the two trackers
  logic       burstInProgress;
  logic       holdLock;
  logic       lateRetry;
  // The same flags bundled for the grant selection
  ctrlStatusT ctrlStatus;

  assign ctrlStatus = '{
    burstInProgress : burstInProgress,
    holdLock        : holdLock,
    lateRetry       : lateRetry
  };

  // --------------------
  // Blocks
  // --------------------

  // Fixed-length burst countdown
  burstTracker u_burstTracker (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .busStatus       (busStatus),
    .burstInProgress (burstInProgress)
  );

  // Lock sampling and retry or split detection
  lockTracker #(
    .numMasters (numMasters)
  ) u_lockTracker (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .busStatus   (busStatus),
    .grantMaster (grantMaster),
    .hLock       (hLock),
    .hMastLock   (hMastLock),
    .holdLock    (holdLock),
    .lateRetry   (lateRetry)
  );

  // Rotating priority, grant decode and owner register
  grantSelect #(
    .numMasters (numMasters)
  ) u_grantSelect (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .busReq      (busReq),
    .ctrlStatus  (ctrlStatus),
    .hMastLock   (hMastLock),
    .hready      (busStatus.hready),
    .grantMaster (grantMaster),
    .hGrant      (hGrant),
    .hMaster     (hMaster)
  );

endmodule

`default_nettype wire

// ==== verilog/ahbPkg.sv ====
// --------------------
// AHB bus definitions shared by the arbiter blocks
// Transfer, burst and response codes plus the bus status bundle
// --------------------
`default_nettype none

package ahbPkg;

  // Field widths of the AHB control signals
  localparam int transWidth = 2;
  localparam int burstWidth = 3;
  localparam int respWidth  = 2;
  localparam int countWidth = 5;

  // Transfer type as driven on HTRANS
  typedef enum logic [transWidth-1:0] {
    transIdle   = 2'b00,
    transBusy   = 2'b01,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } htransT;

  // Burst type as driven on HBURST
  typedef enum logic [burstWidth-1:0] {
    burstSingle = 3'b000,
    burstIncr   = 3'b001,
    burstWrap4  = 3'b010,
    burstIncr4  = 3'b011,
    burstWrap8  = 3'b100,
    burstIncr8  = 3'b101,
    burstWrap16 = 3'b110,
    burstIncr16 = 3'b111
  } hburstT;

  // Slave response as driven on HRESP
  typedef enum logic [respWidth-1:0] {
    respOkay  = 2'b00,
    respError = 2'b01,
    respRetry = 2'b10,
    respSplit = 2'b11
  } hrespT;

  // Beats still to come in a fixed-length burst
  typedef logic [countWidth-1:0] burstCountT;

  // The bus as every arbiter block sees it, 8 bits in all
  typedef struct packed {
    htransT htrans;
    hburstT hburst;
    logic   hready;
    hrespT  hresp;
  } busStatusT;

endpackage

`default_nettype wire

// ==== verilog/arbPkg.sv ====
// --------------------
// Arbiter definitions
// Master numbering and the status flags passed between the arbiter blocks
// --------------------
`default_nettype none

package arbPkg;

  // Five masters by default, master 0 being the dummy master
  localparam int numMastersDefault = 5;

  // Width of a master number, wide enough for up to 8 masters
  localparam int masterIdWidth = 3;

  // Master number as reported on hMaster
  typedef logic [masterIdWidth-1:0] masterIdT;

  // The dummy master only performs idle transfers
  // It owns the bus whenever nobody else asks for it
  localparam masterIdT dummyMaster = masterIdT'(0);

  // --------------------
  // Internal status flags
  // --------------------

  // Hold conditions gathered from the burst and lock trackers
  // The grant selection reads all three to decide whether the owner keeps the bus
  typedef struct packed {
    // A fixed-length burst still has beats to run
    logic burstInProgress;
    // A locked data phase got a retry or split response
    logic holdLock;
    // Second cycle of a retry or split response
    logic lateRetry;
  } ctrlStatusT;

endpackage

`default_nettype wire

// ==== verilog/burstTracker.sv ====
// --------------------
// Burst beat countdown
// Flags a fixed-length burst that must keep its master granted
// --------------------
`default_nettype none

module burstTracker (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  ahbPkg::busStatusT busStatus,
  output logic              burstInProgress
);

  import ahbPkg::*;

  // Beats left in the running burst, and the count for the next cycle
  burstCountT currentCount;
  burstCountT nextCount;

  // --------------------
  // Next count
  // --------------------

  // The load value depends on whether the first address phase is waited
  // A waited first beat is seen again with hready high, hence one more
  // Undefined-length bursts never hold the bus
  always_comb
  begin
    nextCount = currentCount;
    if (!busStatus.hready)
    begin
      if (busStatus.htrans == transNonseq)
      begin
        case (busStatus.hburst)
          burstIncr16, burstWrap16 : nextCount = burstCountT'(15);
          burstIncr8, burstWrap8   : nextCount = burstCountT'(7);
          burstIncr4, burstWrap4   : nextCount = burstCountT'(3);
          default                  : nextCount = '0;
        endcase
      end
    end
    else
    begin
      case (busStatus.htrans)
        transNonseq :
        begin
          case (busStatus.hburst)
            burstIncr16, burstWrap16 : nextCount = burstCountT'(14);
            burstIncr8, burstWrap8   : nextCount = burstCountT'(6);
            burstIncr4, burstWrap4   : nextCount = burstCountT'(2);
            default                  : nextCount = '0;
          endcase
        end
        // Each completed sequential beat takes one off, stopping at zero
        transSeq    : nextCount = (currentCount == '0) ? '0 : currentCount - 1'b1;
        // A busy cycle leaves the count where it is
        transBusy   : nextCount = currentCount;
        // Idle ends the burst at once
        default     : nextCount = '0;
      endcase
    end
  end

  // --------------------
  // Count register
  // --------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      currentCount <= '0;
    end
    else
    begin
      currentCount <= nextCount;
    end
  end

  // The burst holds the bus only while both counts still show beats to run
  assign burstInProgress = (currentCount != '0) && (nextCount != '0);

endmodule

`default_nettype wire

// ==== verilog/grantSelect.sv ====
// --------------------
// Grant selection with rotating priority
// Applies the hold rules, decodes hGrant and registers the address owner
// --------------------
`default_nettype none

module grantSelect #(
  parameter int numMasters = arbPkg::numMastersDefault
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic [numMasters-1:0] busReq,
  input  arbPkg::ctrlStatusT    ctrlStatus,
  input  logic                  hMastLock,
  input  logic                  hready,
  output arbPkg::masterIdT      grantMaster,
  output logic [numMasters-1:0] hGrant,
  output arbPkg::masterIdT      hMaster
);

  import arbPkg::*;

  // Highest ranked requester under the current rotation
  masterIdT topRequest;

  // --------------------
  // Rotating priority
  // --------------------

  // The master one below the address owner ranks highest
  // Ranking goes on downwards and wraps from 0 to numMasters-1
  // The owner itself comes last, so it is only kept when alone
  // The loop walks from lowest to highest rank so the last hit wins
  always_comb
  begin
    int idx;
    topRequest = dummyMaster;
    for (int i = numMasters; i >= 1; i--)
    begin
      idx = (int'(hMaster) + numMasters - i) % numMasters;
      if (busReq[idx])
      begin
        topRequest = masterIdT'(idx);
      end
    end
  end

  // --------------------
  // Hold rules
  // --------------------

  // A locked sequence keeps its owner, as does a lock held over a response
  // A fixed burst also keeps its owner unless a retry or split cut it short
  // In every other case the top requester gets the grant
  always_comb
  begin
    if (hMastLock || ctrlStatus.holdLock)
    begin
      grantMaster = hMaster;
    end
    else if (ctrlStatus.burstInProgress && !ctrlStatus.lateRetry)
    begin
      grantMaster = hMaster;
    end
    else
    begin
      grantMaster = topRequest;
    end
  end

  // One-hot decode of the chosen master
  // Numbers beyond the master count never come out of the selection above
  always_comb
  begin
    for (int i = 0; i < numMasters; i++)
    begin
      hGrant[i] = (grantMaster == masterIdT'(i));
    end
  end

  // --------------------
  // Address owner
  // --------------------

  // The granted master takes the address phase when hready is high
  // While hready is low the current phase is stretched and the owner stays
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hMaster <= dummyMaster;
    end
    else if (hready)
    begin
      hMaster <= grantMaster;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lockTracker.sv ====
// --------------------
// Locked transfer tracking
// Drives hMastLock and holds the lock across a retry or split response
// --------------------
`default_nettype none

module lockTracker #(
  parameter int numMasters = arbPkg::numMastersDefault
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahbPkg::busStatusT     busStatus,
  input  arbPkg::masterIdT      grantMaster,
  input  logic [numMasters-1:0] hLock,
  output logic                  hMastLock,
  output logic                  holdLock,
  output logic                  lateRetry
);

  import ahbPkg::*;
  import arbPkg::*;

  // Lock request of the granted master, or the forced lock during a hold
  logic lockSel;
  // High while the data phase of a locked transfer is on the bus
  logic lockedData;
  // First cycle of a retry or split response, hready still low
  logic retryFirst;

  // --------------------
  // Lock sampling
  // --------------------

  // The lock input of whichever master holds the grant is taken
  // A held lock stays set so no other master slips in
  always_comb
  begin
    lockSel = 1'b0;
    for (int i = 0; i < numMasters; i++)
    begin
      if (grantMaster == masterIdT'(i))
      begin
        lockSel = hLock[i];
      end
    end
    if (holdLock)
    begin
      lockSel = 1'b1;
    end
  end

  // hMastLock marks a locked address phase
  // lockedData trails it by one hready cycle and so marks the data phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hMastLock  <= 1'b0;
      lockedData <= 1'b0;
    end
    else if (busStatus.hready)
    begin
      hMastLock  <= lockSel;
      lockedData <= hMastLock;
    end
  end

  // --------------------
  // Response detection
  // --------------------

  // Retry and split are two-cycle responses with hready low in the first
  // Split is treated the same as retry here
  assign retryFirst = !busStatus.hready &&
                      (busStatus.hresp == respRetry || busStatus.hresp == respSplit);

  // Registered into the second response cycle
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      lateRetry <= 1'b0;
    end
    else
    begin
      lateRetry <= retryFirst;
    end
  end

  // A locked data phase that is retried or split keeps the lock
  assign holdLock = lockedData && lateRetry;

endmodule

`default_nettype wire
